//--- Makefile
# Verilator build and run for the instruction decode stage

VERILATOR ?= verilator
TOP ?= instrDecodeTb
FILELIST ?= instrDecode.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
FAIL_MSG ?= Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected record for one instruction word, built straight from the format table
function automatic decodePkg::decoded_t modelDecode(input decodePkg::instr_t w);
	decodePkg::decoded_t r;
	r = '0;
	r.opcode = decodePkg::opcode_t'(w[6:0]);
	r.rt = w[12:7];
	r.prec = decodePkg::PREC64;
	r.unit = decodePkg::UNIT_ALU;
	// Writing register zero is never a real write
	r.rtWrite = (w[12:7] != 6'd0);
	case (r.opcode)
	decodePkg::OP_R2:
	begin
		r.ra = w[18:13];
		r.rb = w[24:19];
		r.prec = decodePkg::prec_t'(w[32:31]);
	end
	// Long immediate group, the multiply goes to its own unit
	decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI, decodePkg::OP_MULI,
	decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI:
	begin
		r.ra = w[18:13];
		r.prec = decodePkg::prec_t'(w[20:19]);
		r.imm = {{45{w[39]}}, w[39:21]};
		if (r.opcode == decodePkg::OP_MULI)
			r.unit = decodePkg::UNIT_MUL;
	end
	// Short immediate group reads and writes the same register
	decodePkg::OP_ADDSI, decodePkg::OP_ORSI, decodePkg::OP_ANDSI, decodePkg::OP_EORSI:
	begin
		r.ra = w[12:7];
		r.prec = decodePkg::prec_t'(w[17:16]);
		r.imm = {{42{w[39]}}, w[39:18]};
	end
	decodePkg::OP_SHIFT, decodePkg::OP_FLT3:
	begin
		r.ra = w[18:13];
		r.rb = w[24:19];
		r.rc = w[30:25];
		r.prec = decodePkg::prec_t'(w[35:34]);
		if (r.opcode == decodePkg::OP_FLT3)
			r.unit = decodePkg::UNIT_FPU;
	end
	decodePkg::OP_BSR:
	begin
		r.imm = {{45{w[39]}}, w[39:21]};
		r.unit = decodePkg::UNIT_BRANCH;
	end
	decodePkg::OP_CHK:
	begin
		r.unit = decodePkg::UNIT_BRANCH;
		r.rtWrite = 1'b0;
	end
	decodePkg::OP_CSR:
		r.unit = decodePkg::UNIT_CSR;
	decodePkg::OP_MOV:
		r.unit = decodePkg::UNIT_ALU;
	// NOP and every undefined code
	default:
	begin
		r.unit = decodePkg::UNIT_NONE;
		r.rtWrite = 1'b0;
	end
	endcase
	return r;
endfunction

`endif

//--- dv/instrDecodeTb.sv
`timescale 1ns/100ps

module instrDecodeTb;

	logic clk;
	logic rst;
	logic inValid;
	decodePkg::instr_t instr;
	logic outReady;
	logic inReady;
	logic outValid;
	decodePkg::decoded_t decoded;

	// Expected records and the edge at which each was accepted
	decodePkg::decoded_t expQ[$];
	int acceptQ[$];
	bit holding;
	int acceptCount;
	int edgeCount;
	int errorCount;
	int testsPassed;
	int testsFailed;

	logic [6:0] allOps [19] = '{
		decodePkg::OP_R2, decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
		decodePkg::OP_MULI, decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI,
		decodePkg::OP_ADDSI, decodePkg::OP_ORSI, decodePkg::OP_ANDSI, decodePkg::OP_EORSI,
		decodePkg::OP_SHIFT, decodePkg::OP_FLT3, decodePkg::OP_CSR, decodePkg::OP_MOV,
		decodePkg::OP_NOP, decodePkg::OP_BSR, decodePkg::OP_CHK
	};
	// Every opcode that carries an immediate or a displacement
	logic [6:0] immOps [12] = '{
		decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI, decodePkg::OP_MULI,
		decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI, decodePkg::OP_ADDSI,
		decodePkg::OP_ORSI, decodePkg::OP_ANDSI, decodePkg::OP_EORSI, decodePkg::OP_BSR
	};

	`include "decodeModel.svh"

	instrDecode u_instrDecode (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.inReady(inReady),
		.outValid(outValid),
		.decoded(decoded),
		.outReady(outReady)
	);

	always #4 clk = ~clk;

	// ==================================================
	// Stimulus helpers
	// ==================================================

	function automatic bit isDefined(input logic [6:0] v);
		for (int i = 0; i < 19; i++)
			if (allOps[i] == v)
				return 1'b1;
		return 1'b0;
	endfunction

	// Walk upward from a random code until it hits a gap in the opcode map
	function automatic logic [6:0] undefinedOpcode();
		logic [6:0] v;
		v = 7'($urandom());
		while (isDefined(v))
			v = v + 7'd1;
		return v;
	endfunction

	function automatic decodePkg::instr_t randomInstr(input int idx, input int undefPer8,
		input bit immBias);
		decodePkg::instr_t w;
		logic [6:0] op;
		w[31:0] = $urandom();
		w[39:32] = 8'($urandom());
		if ($urandom_range(7) < undefPer8)
			op = undefinedOpcode();
		else if (immBias && $urandom_range(3) != 0)
			op = immOps[$urandom_range(11)];
		else
			op = allOps[$urandom_range(18)];
		w[6:0] = op;
		// Sign bit alternates so both extensions get exercised
		w[39] = idx[0];
		if ($urandom_range(3) == 0)
			w[12:7] = 6'd0;
		return w;
	endfunction

	// ==================================================
	// Checks
	// ==================================================

	task automatic reportMismatch(input string name, input string field, input logic [63:0] e,
		input logic [63:0] a);
		errorCount++;
		$display("ERROR %s %s: expected %0h, actual %0h", name, field, e, a);
	endtask

	task automatic checkDecoded(input string name, input decodePkg::decoded_t e,
		input decodePkg::decoded_t a);
		if (a.opcode !== e.opcode)
			reportMismatch(name, "opcode", 64'(e.opcode), 64'(a.opcode));
		if (a.unit !== e.unit)
			reportMismatch(name, "unit", 64'(e.unit), 64'(a.unit));
		if (a.prec !== e.prec)
			reportMismatch(name, "prec", 64'(e.prec), 64'(a.prec));
		if (a.rt !== e.rt)
			reportMismatch(name, "rt", 64'(e.rt), 64'(a.rt));
		if (a.ra !== e.ra)
			reportMismatch(name, "ra", 64'(e.ra), 64'(a.ra));
		if (a.rb !== e.rb)
			reportMismatch(name, "rb", 64'(e.rb), 64'(a.rb));
		if (a.rc !== e.rc)
			reportMismatch(name, "rc", 64'(e.rc), 64'(a.rc));
		if (a.rtWrite !== e.rtWrite)
			reportMismatch(name, "rtWrite", 64'(e.rtWrite), 64'(a.rtWrite));
		if (a.imm !== e.imm)
			reportMismatch(name, "imm", e.imm, a.imm);
	endtask

	task automatic checkBit(input string name, input logic e, input logic a);
		if (a !== e)
		begin
			errorCount++;
			$display("ERROR %s: expected %b, actual %b", name, e, a);
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errorCount == startErrors)
		begin
			testsPassed++;
			$display("PASS %s", name);
		end
		else
		begin
			testsFailed++;
			$display("FAIL %s with %0d errors", name, errorCount - startErrors);
		end
	endtask

	// ==================================================
	// One clock of traffic
	// ==================================================

	// Inputs change on the falling edge
	// Everything is sampled 1 ns before the rising edge
	task automatic driveCycle(input bit offer, input decodePkg::instr_t w, input bit rdy,
		input string name, input bit steady);
		decodePkg::decoded_t e;
		int edgeAt;
		@(negedge clk);
		// An offered word stays on the bus until it is taken
		if (!holding)
		begin
			inValid = offer;
			instr = w;
		end
		holding = inValid;
		outReady = rdy;
		#3;
		// Only two full stages with nothing leaving stall the input
		checkBit({name, " inReady"}, expQ.size() < 2 || outReady, inReady);
		if (inValid && inReady)
		begin
			expQ.push_back(modelDecode(instr));
			acceptQ.push_back(edgeCount);
			acceptCount++;
			holding = 1'b0;
		end
		if (outValid && outReady)
		begin
			if (expQ.size() == 0)
			begin
				errorCount++;
				$display("%s: the DUT delivered a record with no instruction outstanding", name);
			end
			else
			begin
				e = expQ.pop_front();
				edgeAt = acceptQ.pop_front();
				checkDecoded(name, e, decoded);
				if (steady && edgeCount - edgeAt != 2)
				begin
					errorCount++;
					$display("%s: a record left %0d edges after acceptance instead of 2",
						name, edgeCount - edgeAt);
				end
			end
		end
		edgeCount++;
	endtask

	// Sends count instructions and then drains the DUT
	// Without randomFlow both valid and ready stay high
	task automatic runTraffic(input string name, input int count, input int undefPer8,
		input bit immBias, input bit randomFlow);
		int startErrors;
		int offered;
		int guard;
		bit offer;
		bit rdy;
		decodePkg::instr_t w;
		startErrors = errorCount;
		offered = 0;
		acceptCount = 0;
		guard = 0;
		while (acceptCount < count && guard < count * 20)
		begin
			offer = 1'b0;
			w = instr;
			if (!holding && offered < count && (!randomFlow || $urandom_range(9) < 7))
			begin
				w = randomInstr(offered, undefPer8, immBias);
				offer = 1'b1;
				offered++;
			end
			rdy = !randomFlow || $urandom_range(9) < 6;
			driveCycle(offer, w, rdy, name, !randomFlow);
			guard++;
		end
		if (acceptCount < count)
		begin
			errorCount++;
			$display("%s: timed out with only %0d of %0d instructions accepted",
				name, acceptCount, count);
		end
		guard = 0;
		while (expQ.size() != 0 && guard < 200)
		begin
			rdy = !randomFlow || $urandom_range(9) < 6;
			driveCycle(1'b0, instr, rdy, name, !randomFlow);
			guard++;
		end
		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("%s: timed out with %0d records still inside the DUT", name, expQ.size());
		end
		finishTest(name, startErrors);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin
		int startErrors;
		void'($urandom(32'hc987_59c0));
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		holding = 1'b0;
		acceptCount = 0;
		edgeCount = 0;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#3;
		startErrors = errorCount;
		checkBit("reset outValid", 1'b0, outValid);
		checkBit("reset inReady", 1'b1, inReady);
		finishTest("reset", startErrors);

		runTraffic("precision", 200, 0, 1'b0, 1'b0);
		runTraffic("immediate", 200, 0, 1'b1, 1'b0);
		runTraffic("operands", 300, 0, 1'b0, 1'b1);
		runTraffic("flow steady", 150, 1, 1'b0, 1'b0);
		runTraffic("flow random", 400, 1, 1'b0, 1'b1);
		runTraffic("undefined", 100, 8, 1'b0, 1'b1);

		$display("Tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- instrDecode.f
+incdir+dv
source/decodePkg.sv
source/decodePrec.sv
source/decodeImm.sv
source/decodeOperands.sv
source/stageReg.sv
source/decodeCtrl.sv
source/instrDecode.sv
dv/instrDecodeTb.sv

//--- source/decodeCtrl.sv
`timescale 1ns/100ps

module decodeCtrl (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output logic load1,
	output logic load2
);

	// One full bit per stage
	logic full1;
	logic full2;

	// ==================================================
	// Handshake and load enables
	// ==================================================

	// Stage two can take a record when it is empty or its record leaves this cycle
	assign load2 = full1 && (!full2 || outReady);

	// Stage one accepts when it is empty or its content moves on
	assign inReady = !full1 || load2;
	assign load1 = inValid && inReady;

	assign outValid = full2;

	// ==================================================
	// Occupancy
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			full1 <= 1'b0;
			full2 <= 1'b0;
		end
		else
		begin
			// A new word wins over a drain in the same cycle
			if (load1)
				full1 <= 1'b1;
			else if (load2)
				full1 <= 1'b0;
			// Stage two refills or empties when its record is taken
			if (load2)
				full2 <= 1'b1;
			else if (outReady)
				full2 <= 1'b0;
		end
	end

endmodule

//--- source/decodeImm.sv
`timescale 1ns/100ps

module decodeImm (
	input decodePkg::instr_t instr,
	output logic [decodePkg::immWidth-1:0] imm
);

	decodePkg::opcode_t op;

	assign op = decodePkg::opcode_t'(instr[decodePkg::opMsb:decodePkg::opLsb]);

	// Sign bit of each immediate is the top bit of the word
	always_comb
	begin
		case (op)
		// The branch displacement reuses the long immediate layout
		decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
		decodePkg::OP_MULI, decodePkg::OP_ANDI, decodePkg::OP_ORI,
		decodePkg::OP_EORI, decodePkg::OP_BSR:
		begin
			imm = {
				{(decodePkg::immWidth - decodePkg::immLongWidth){instr[decodePkg::immLongMsb]}},
				instr[decodePkg::immLongMsb:decodePkg::immLongLsb]
			};
		end
		decodePkg::OP_ADDSI, decodePkg::OP_ORSI, decodePkg::OP_ANDSI,
		decodePkg::OP_EORSI:
		begin
			imm = {
				{(decodePkg::immWidth - decodePkg::immShortWidth){instr[decodePkg::immShortMsb]}},
				instr[decodePkg::immShortMsb:decodePkg::immShortLsb]
			};
		end
		// No constant in any other format
		default:
		begin
			imm = '0;
		end
		endcase
	end

endmodule

//--- source/decodeOperands.sv
`timescale 1ns/100ps

module decodeOperands (
	input decodePkg::instr_t instr,
	output decodePkg::regNum_t rt,
	output decodePkg::regNum_t ra,
	output decodePkg::regNum_t rb,
	output decodePkg::regNum_t rc,
	output logic rtWrite,
	output decodePkg::unit_t unit
);

	decodePkg::opcode_t op;

	assign op = decodePkg::opcode_t'(instr[decodePkg::opMsb:decodePkg::opLsb]);

	// Rt has the same position in every format
	assign rt = instr[decodePkg::rtMsb:decodePkg::rtLsb];

	// Source fields, zero where the format has none
	always_comb
	begin
		ra = '0;
		rb = '0;
		rc = '0;
		rtWrite = (rt != '0);
		unit = decodePkg::UNIT_ALU;
		case (op)
		decodePkg::OP_R2:
		begin
			ra = instr[decodePkg::raMsb:decodePkg::raLsb];
			rb = instr[decodePkg::rbMsb:decodePkg::rbLsb];
		end
		decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
		decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI:
		begin
			ra = instr[decodePkg::raMsb:decodePkg::raLsb];
		end
		decodePkg::OP_MULI:
		begin
			ra = instr[decodePkg::raMsb:decodePkg::raLsb];
			unit = decodePkg::UNIT_MUL;
		end
		// Short immediate ops are two-address, Rt is also the source
		decodePkg::OP_ADDSI, decodePkg::OP_ORSI, decodePkg::OP_ANDSI,
		decodePkg::OP_EORSI:
		begin
			ra = rt;
		end
		decodePkg::OP_SHIFT, decodePkg::OP_FLT3:
		begin
			ra = instr[decodePkg::raMsb:decodePkg::raLsb];
			rb = instr[decodePkg::rbMsb:decodePkg::rbLsb];
			rc = instr[decodePkg::rcMsb:decodePkg::rcLsb];
			if (op == decodePkg::OP_FLT3)
				unit = decodePkg::UNIT_FPU;
		end
		decodePkg::OP_MOV:
		begin
			unit = decodePkg::UNIT_ALU;
		end
		// BSR writes the link register, CHK only traps
		decodePkg::OP_BSR:
		begin
			unit = decodePkg::UNIT_BRANCH;
		end
		decodePkg::OP_CHK:
		begin
			rtWrite = 1'b0;
			unit = decodePkg::UNIT_BRANCH;
		end
		decodePkg::OP_CSR:
		begin
			unit = decodePkg::UNIT_CSR;
		end
		// NOP and undefined codes touch no unit and write nothing
		default:
		begin
			rtWrite = 1'b0;
			unit = decodePkg::UNIT_NONE;
		end
		endcase
	end

endmodule

//--- source/decodePkg.sv
package decodePkg;

	// ==================================================
	// Widths
	// ==================================================

	localparam int instrWidth = 40;
	localparam int immWidth = 64;

	// A whole instruction word as it arrives from fetch
	typedef logic [instrWidth-1:0] instr_t;

	// Register numbers cover 64 architectural registers
	typedef logic [5:0] regNum_t;

	// ==================================================
	// Field positions
	// ==================================================

	// Opcode and Rt sit at the same place in every format
	localparam int opLsb = 0;
	localparam int opMsb = 6;
	localparam int rtLsb = 7;
	localparam int rtMsb = 12;

	// Source registers of the register and three-source formats
	localparam int raLsb = 13;
	localparam int raMsb = 18;
	localparam int rbLsb = 19;
	localparam int rbMsb = 24;
	localparam int rcLsb = 25;
	localparam int rcMsb = 30;

	// Precision field, one position per format
	localparam int precRegLsb = 31;
	localparam int precRegMsb = 32;
	localparam int precLongLsb = 19;
	localparam int precLongMsb = 20;
	localparam int precShortLsb = 16;
	localparam int precShortMsb = 17;
	localparam int prec3Lsb = 34;
	localparam int prec3Msb = 35;

	// Immediates always run up to the top bit of the word
	localparam int immLongLsb = 21;
	localparam int immLongMsb = 39;
	localparam int immLongWidth = immLongMsb - immLongLsb + 1;
	localparam int immShortLsb = 18;
	localparam int immShortMsb = 39;
	localparam int immShortWidth = immShortMsb - immShortLsb + 1;

	// ==================================================
	// Encodings
	// ==================================================

	// Codes not listed here are undefined and decode as a no-op
	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_CSR   = 7'h03,
		OP_ADDI  = 7'h04,
		OP_SUBFI = 7'h05,
		OP_CMPI  = 7'h06,
		OP_MULI  = 7'h07,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_EORI  = 7'h0A,
		OP_CHK   = 7'h0B,
		OP_MOV   = 7'h0F,
		OP_ADDSI = 7'h14,
		OP_ANDSI = 7'h18,
		OP_ORSI  = 7'h19,
		OP_EORSI = 7'h1A,
		OP_BSR   = 7'h20,
		OP_SHIFT = 7'h2E,
		OP_FLT3  = 7'h2F,
		OP_NOP   = 7'h7F
	} opcode_t;

	typedef enum logic [1:0] {
		PREC8  = 2'd0,
		PREC16 = 2'd1,
		PREC32 = 2'd2,
		PREC64 = 2'd3
	} prec_t;

	typedef enum logic [2:0] {
		UNIT_NONE,
		UNIT_ALU,
		UNIT_MUL,
		UNIT_FPU,
		UNIT_BRANCH,
		UNIT_CSR
	} unit_t;

	// One record per instruction, handed to the issue logic
	typedef struct packed {
		opcode_t opcode;
		unit_t unit;
		prec_t prec;
		regNum_t rt;
		regNum_t ra;
		regNum_t rb;
		regNum_t rc;
		logic rtWrite;
		logic [immWidth-1:0] imm;
	} decoded_t;

endpackage

//--- source/decodePrec.sv
`timescale 1ns/100ps

module decodePrec (
	input decodePkg::instr_t instr,
	output decodePkg::prec_t prec
);

	// Each format keeps its two precision bits at a different place
	function automatic decodePkg::prec_t fnPrec(input decodePkg::instr_t ir);
		decodePkg::opcode_t op;
		op = decodePkg::opcode_t'(ir[decodePkg::opMsb:decodePkg::opLsb]);
		case (op)
		decodePkg::OP_R2:
			fnPrec = decodePkg::prec_t'(ir[decodePkg::precRegMsb:decodePkg::precRegLsb]);
		// Long immediate ops share one layout
		decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
		decodePkg::OP_MULI, decodePkg::OP_ANDI, decodePkg::OP_ORI,
		decodePkg::OP_EORI:
			fnPrec = decodePkg::prec_t'(ir[decodePkg::precLongMsb:decodePkg::precLongLsb]);
		// Short immediate ops give up Ra to widen the constant
		decodePkg::OP_ADDSI, decodePkg::OP_ORSI, decodePkg::OP_ANDSI,
		decodePkg::OP_EORSI:
			fnPrec = decodePkg::prec_t'(ir[decodePkg::precShortMsb:decodePkg::precShortLsb]);
		decodePkg::OP_SHIFT, decodePkg::OP_FLT3:
			fnPrec = decodePkg::prec_t'(ir[decodePkg::prec3Msb:decodePkg::prec3Lsb]);
		// Checks, CSR access, moves, branches and undefined codes work on full registers
		default:
			fnPrec = decodePkg::PREC64;
		endcase
	endfunction

	assign prec = fnPrec(instr);

endmodule

//--- source/instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
	input logic clk,
	input logic rst,
	input logic inValid,
	input decodePkg::instr_t instr,
	output logic inReady,
	output logic outValid,
	output decodePkg::decoded_t decoded,
	input logic outReady
);

	logic load1;
	logic load2;
	decodePkg::instr_t instr1;
	decodePkg::decoded_t dec1;

	decodeCtrl u_decodeCtrl (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.outReady(outReady),
		.inReady(inReady),
		.outValid(outValid),
		.load1(load1),
		.load2(load2)
	);

	// ==================================================
	// Stage one holds the raw word
	// ==================================================

	stageReg #(.payload_t(decodePkg::instr_t)) u_stage1 (
		.clk(clk),
		.rst(rst),
		.load(load1),
		.d(instr),
		.q(instr1)
	);

	// The three decoders work on the stage one word in parallel
	assign dec1.opcode = decodePkg::opcode_t'(instr1[decodePkg::opMsb:decodePkg::opLsb]);

	decodePrec u_decodePrec (
		.instr(instr1),
		.prec(dec1.prec)
	);

	decodeImm u_decodeImm (
		.instr(instr1),
		.imm(dec1.imm)
	);

	decodeOperands u_decodeOperands (
		.instr(instr1),
		.rt(dec1.rt),
		.ra(dec1.ra),
		.rb(dec1.rb),
		.rc(dec1.rc),
		.rtWrite(dec1.rtWrite),
		.unit(dec1.unit)
	);

	// Stage two holds the finished record
	stageReg #(.payload_t(decodePkg::decoded_t)) u_stage2 (
		.clk(clk),
		.rst(rst),
		.load(load2),
		.d(dec1),
		.q(decoded)
	);

endmodule

//--- source/stageReg.sv
`timescale 1ns/100ps

module stageReg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst,
	input logic load,
	input payload_t d,
	output payload_t q
);

	// Holds its payload until the control module loads a new one
	always_ff @(posedge clk)
	begin
		if (rst)
			q <= '0;
		else if (load)
			q <= d;
	end

endmodule
